//--- src/kr580_pkg.sv
package kr580_pkg;

    // --------------------------------------------------
    // Widths and basic types
    // --------------------------------------------------
    localparam int data_width = 8;
    localparam int addr_width = 16;

    typedef logic [data_width-1:0] byte_t;
    typedef logic [addr_width-1:0] addr_t;

    // Bit positions within F
    localparam int flag_cf = 0;
    localparam int flag_nf = 1;
    localparam int flag_pf = 2;
    localparam int flag_af = 4;
    localparam int flag_zf = 6;
    localparam int flag_sf = 7;

    localparam byte_t flags_reset = 8'h40;     // Only ZF set

    // --------------------------------------------------
    // Opcode field encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        r8_b = 3'd0,
        r8_c = 3'd1,
        r8_d = 3'd2,
        r8_e = 3'd3,
        r8_h = 3'd4,
        r8_l = 3'd5,
        r8_m = 3'd6,                            // Memory operand, reads back F
        r8_a = 3'd7
    } reg8_e;

    typedef enum logic [1:0] {
        rp_bc = 2'd0,
        rp_de = 2'd1,
        rp_hl = 2'd2,
        rp_sp = 2'd3
    } reg16_e;

    // Same order as bits 5:3 of the ALU opcodes
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_adc = 3'd1,
        alu_sub = 3'd2,
        alu_sbc = 3'd3,
        alu_and = 3'd4,
        alu_xor = 3'd5,
        alu_or  = 3'd6,
        alu_cp  = 3'd7
    } alu_op_e;

    typedef enum logic [3:0] {
        cls_nop,
        cls_mvi,
        cls_lxi,
        cls_mov,
        cls_alu_r,
        cls_alu_i,
        cls_jmp,
        cls_out,
        cls_in,
        cls_hlt,
        cls_illegal                             // Runs as NOP
    } instr_class_e;

    // --------------------------------------------------
    // Structs passed between blocks
    // --------------------------------------------------
    typedef struct packed {
        instr_class_e iclass;
        reg8_e        dst;
        reg8_e        src;
        reg16_e       pair;
        alu_op_e      alu_op;
        logic [2:0]   cond;
    } decode_t;

    typedef struct packed {
        logic   byte_en;
        logic   word_en;
        reg8_e  idx8;
        reg16_e idx16;
        byte_t  data_lo;
        byte_t  data_hi;                        // Word writes only
    } reg_write_t;

endpackage

//--- src/alu.sv
`timescale 1ns/1ps

module alu import kr580_pkg::*; (
    input  byte_t   a,
    input  byte_t   b,
    input  alu_op_e op,
    input  logic    carry_in,
    output byte_t   result,
    output byte_t   flags
);

    logic [8:0] wide;                           // Bit 8 is carry or borrow
    logic       arith;
    logic       subtract;
    logic       overflow;
    logic       parity_even;
    logic       aux;

    assign arith    = (op inside {alu_add, alu_adc, alu_sub, alu_sbc, alu_cp});
    assign subtract = (op inside {alu_sub, alu_sbc, alu_cp});

    always_comb begin
        unique case (op)
            alu_add: wide = {1'b0, a} + {1'b0, b};
            alu_adc: wide = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
            alu_sub,
            alu_cp:  wide = {1'b0, a} - {1'b0, b};
            alu_sbc: wide = {1'b0, a} - {1'b0, b} - {8'd0, carry_in};
            alu_and: wide = {1'b0, a & b};
            alu_xor: wide = {1'b0, a ^ b};
            alu_or:  wide = {1'b0, a | b};
        endcase
    end

    assign result = wide[7:0];

    // --------------------------------------------------
    // Flag terms
    // --------------------------------------------------
    // Carry into bit 4, the same for sum and difference
    assign aux         = a[4] ^ b[4] ^ wide[4];
    assign parity_even = ~^wide[7:0];

    always_comb begin
        if (subtract) begin
            overflow = (a[7] != b[7]) && (a[7] != wide[7]);
        end else begin
            overflow = (a[7] == b[7]) && (a[7] != wide[7]);
        end
    end

    always_comb begin
        flags          = '0;
        flags[flag_sf] = wide[7];
        flags[flag_zf] = (wide[7:0] == 8'd0);
        flags[flag_af] = arith && aux;          // Cleared by the logic ops
        flags[flag_pf] = arith ? overflow : parity_even;
        flags[flag_nf] = subtract;
        flags[flag_cf] = arith && wide[8];
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps

module register_file import kr580_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    input  reg8_e      reg8_sel,
    output byte_t      reg8_rdata,
    output byte_t      acc,
    output byte_t      flags,
    input  reg_write_t reg_write,
    input  logic       flag_we,
    input  byte_t      flag_wdata
);

    addr_t bc;
    addr_t de;
    addr_t hl;
    addr_t sp;                                  // Loaded by LXI SP only
    byte_t a;
    byte_t f;

    assign acc   = a;
    assign flags = f;

    // Byte read port
    always_comb begin
        unique case (reg8_sel)
            r8_b: reg8_rdata = bc[15:8];
            r8_c: reg8_rdata = bc[7:0];
            r8_d: reg8_rdata = de[15:8];
            r8_e: reg8_rdata = de[7:0];
            r8_h: reg8_rdata = hl[15:8];
            r8_l: reg8_rdata = hl[7:0];
            r8_m: reg8_rdata = f;
            r8_a: reg8_rdata = a;
        endcase
    end

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bc <= '0;
            de <= '0;
            hl <= '0;
            sp <= '0;
            a  <= '0;
            f  <= flags_reset;
        end else begin
            if (reg_write.word_en) begin
                unique case (reg_write.idx16)
                    rp_bc: bc <= {reg_write.data_hi, reg_write.data_lo};
                    rp_de: de <= {reg_write.data_hi, reg_write.data_lo};
                    rp_hl: hl <= {reg_write.data_hi, reg_write.data_lo};
                    rp_sp: sp <= {reg_write.data_hi, reg_write.data_lo};
                endcase
            end else if (reg_write.byte_en) begin
                unique case (reg_write.idx8)
                    r8_b: bc[15:8] <= reg_write.data_lo;
                    r8_c: bc[7:0]  <= reg_write.data_lo;
                    r8_d: de[15:8] <= reg_write.data_lo;
                    r8_e: de[7:0]  <= reg_write.data_lo;
                    r8_h: hl[15:8] <= reg_write.data_lo;
                    r8_l: hl[7:0]  <= reg_write.data_lo;
                    r8_a: a        <= reg_write.data_lo;
                    default: ;                  // M has no storage here
                endcase
            end
            if (flag_we) begin
                f <= flag_wdata;
            end
        end
    end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import kr580_pkg::*; (
    input  byte_t   opcode,
    output decode_t decode
);

    reg8_e dst;
    reg8_e src;
    logic  dst_is_m;
    logic  src_is_m;

    // Register fields sit at the same place in every class
    assign dst      = reg8_e'(opcode[5:3]);
    assign src      = reg8_e'(opcode[2:0]);
    assign dst_is_m = (dst == r8_m);
    assign src_is_m = (src == r8_m);

    always_comb begin
        decode.dst    = dst;
        decode.src    = src;
        decode.pair   = reg16_e'(opcode[5:4]);
        decode.alu_op = alu_op_e'(opcode[5:3]);
        decode.cond   = opcode[5:3];
        decode.iclass = cls_illegal;

        // 0x76 listed ahead of the MOV block so HLT wins
        casez (opcode)
            8'h00:
                decode.iclass = cls_nop;
            8'h76:
                decode.iclass = cls_hlt;
            8'b00_??0_001:
                decode.iclass = cls_lxi;
            8'b00_???_110: begin
                if (!dst_is_m) begin
                    decode.iclass = cls_mvi;
                end
            end
            8'b01_???_???: begin
                if (!dst_is_m && !src_is_m) begin
                    decode.iclass = cls_mov;
                end
            end
            8'b10_???_???: begin
                if (!src_is_m) begin
                    decode.iclass = cls_alu_r;
                end
            end
            8'b11_???_110:
                decode.iclass = cls_alu_i;
            8'b11_000_011,                      // JMP
            8'b11_???_010:                      // Jcc
                decode.iclass = cls_jmp;
            8'hd3:
                decode.iclass = cls_out;
            8'hdb:
                decode.iclass = cls_in;
            default:
                decode.iclass = cls_illegal;
        endcase
    end

endmodule

//--- src/instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer import kr580_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    input  byte_t      in,
    input  byte_t      pin_pi,
    output byte_t      opcode,
    input  decode_t    decode,
    input  byte_t      flags,
    input  byte_t      acc,
    output reg8_e      reg8_sel,
    input  byte_t      reg8_rdata,
    output byte_t      alu_a,
    output byte_t      alu_b,
    output alu_op_e    alu_op,
    input  byte_t      alu_result,
    input  byte_t      alu_flags,
    output reg_write_t reg_write,
    output logic       flag_we,
    output byte_t      flag_wdata,
    output addr_t      address,
    output byte_t      pin_pa,
    output byte_t      pin_po,
    output logic       pin_pw,
    output logic       halted
);

    logic [1:0] tstate;
    logic [1:0] last_t;                         // Final t-state of the current class
    byte_t      opcode_q;
    byte_t      imm_lo;
    addr_t      pc;
    addr_t      pc_next;
    logic       cond_flag;
    logic       jump_taken;

    assign opcode     = (tstate == 2'd0) ? in : opcode_q;
    assign address    = pc;
    assign flag_wdata = alu_flags;
    assign reg8_sel   = decode.src;

    // --------------------------------------------------
    // Jump condition
    // --------------------------------------------------
    always_comb begin
        unique case (decode.cond[2:1])
            2'd0: cond_flag = flags[flag_zf];   // NZ / Z
            2'd1: cond_flag = flags[flag_cf];   // NC / C
            2'd2: cond_flag = flags[flag_pf];   // PO / PE
            2'd3: cond_flag = flags[flag_sf];   // P / M
        endcase
        // Bit 0 set only on the unconditional JMP
        jump_taken = opcode[0] || (cond_flag == decode.cond[0]);
    end

    // --------------------------------------------------
    // Step length, PC advance and register writes
    // --------------------------------------------------
    always_comb begin
        unique case (decode.iclass)
            cls_mov, cls_mvi, cls_out:                      last_t = 2'd1;
            cls_lxi, cls_alu_r, cls_alu_i, cls_jmp, cls_in: last_t = 2'd2;
            default:                                        last_t = 2'd0;
        endcase

        pc_next = pc;
        if (tstate == 2'd0) begin
            pc_next = pc + 16'd1;               // Past the opcode
        end else if (tstate == 2'd1 && decode.iclass inside
                     {cls_mvi, cls_out, cls_lxi, cls_alu_i, cls_jmp, cls_in}) begin
            pc_next = pc + 16'd1;               // Past the first operand byte
        end else if (tstate == 2'd2 && decode.iclass == cls_lxi) begin
            pc_next = pc + 16'd1;
        end else if (tstate == 2'd2 && decode.iclass == cls_jmp) begin
            pc_next = jump_taken ? {in, imm_lo} : pc + 16'd1;
        end

        reg_write = '0;
        flag_we   = 1'b0;
        unique case (decode.iclass)
            cls_mvi: if (tstate == 2'd1) begin
                reg_write.byte_en = 1'b1;
                reg_write.idx8    = decode.dst;
                reg_write.data_lo = in;
            end
            cls_mov: if (tstate == 2'd1) begin
                reg_write.byte_en = 1'b1;
                reg_write.idx8    = decode.dst;
                reg_write.data_lo = reg8_rdata;
            end
            cls_lxi: if (tstate == 2'd2) begin
                reg_write.word_en = 1'b1;
                reg_write.idx16   = decode.pair;
                reg_write.data_lo = imm_lo;
                reg_write.data_hi = in;
            end
            cls_alu_r, cls_alu_i: if (tstate == 2'd2) begin
                reg_write.byte_en = (alu_op != alu_cp);   // CP only sets flags
                reg_write.idx8    = r8_a;
                reg_write.data_lo = alu_result;
                flag_we           = 1'b1;
            end
            cls_in: if (tstate == 2'd2) begin
                reg_write.byte_en = 1'b1;
                reg_write.idx8    = r8_a;
                reg_write.data_lo = pin_pi;
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // Control state
    // --------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tstate <= 2'd0;
            pc     <= '0;
            pin_pa <= '0;
            pin_po <= '0;
            pin_pw <= 1'b0;
            halted <= 1'b0;
        end else begin
            pin_pw <= 1'b0;
            if (!halted) begin
                tstate <= (tstate == last_t) ? 2'd0 : tstate + 2'd1;
                pc     <= pc_next;
                if (decode.iclass == cls_hlt) begin
                    halted <= 1'b1;             // Stays set until reset
                end
                if (decode.iclass == cls_out && tstate == 2'd1) begin
                    pin_pa <= in;
                    pin_po <= acc;
                    pin_pw <= 1'b1;
                end
            end
        end
    end

    // Opcode, immediate and ALU operand latches
    always_ff @(posedge clock) begin
        if (tstate == 2'd0) begin
            opcode_q <= in;
        end
        if (!halted) begin
            if (tstate == 2'd1 && decode.iclass inside {cls_lxi, cls_jmp}) begin
                imm_lo <= in;
            end
            if (decode.iclass inside {cls_alu_r, cls_alu_i}) begin
                if (tstate == 2'd0) begin
                    alu_a  <= acc;
                    alu_op <= decode.alu_op;
                end else if (tstate == 2'd1) begin
                    alu_b  <= (decode.iclass == cls_alu_i) ? in : reg8_rdata;
                end
            end
        end
    end

endmodule

//--- src/kr580_core.sv
`timescale 1ns/1ps

module kr580_core import kr580_pkg::*; (
    input  logic  clock,
    input  logic  arst_n,
    input  byte_t in,
    input  byte_t pin_pi,
    output addr_t address,
    output byte_t pin_pa,
    output byte_t pin_po,
    output logic  pin_pw,
    output logic  halted
);

    byte_t      opcode;
    decode_t    decode;
    reg8_e      reg8_sel;
    byte_t      reg8_rdata;
    byte_t      acc;
    byte_t      flags;
    byte_t      alu_a;
    byte_t      alu_b;
    alu_op_e    alu_op;
    byte_t      alu_result;
    byte_t      alu_flags;
    reg_write_t reg_write;
    logic       flag_we;
    byte_t      flag_wdata;

    instr_decoder u_decoder (
        .opcode (opcode),
        .decode (decode)
    );

    instr_sequencer u_sequencer (
        .clock      (clock),
        .arst_n     (arst_n),
        .in         (in),
        .pin_pi     (pin_pi),
        .opcode     (opcode),
        .decode     (decode),
        .flags      (flags),
        .acc        (acc),
        .reg8_sel   (reg8_sel),
        .reg8_rdata (reg8_rdata),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .reg_write  (reg_write),
        .flag_we    (flag_we),
        .flag_wdata (flag_wdata),
        .address    (address),
        .pin_pa     (pin_pa),
        .pin_po     (pin_po),
        .pin_pw     (pin_pw),
        .halted     (halted)
    );

    alu u_alu (
        .a        (alu_a),
        .b        (alu_b),
        .op       (alu_op),
        .carry_in (flags[flag_cf]),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    register_file u_regs (
        .clock      (clock),
        .arst_n     (arst_n),
        .reg8_sel   (reg8_sel),
        .reg8_rdata (reg8_rdata),
        .acc        (acc),
        .flags      (flags),
        .reg_write  (reg_write),
        .flag_we    (flag_we),
        .flag_wdata (flag_wdata)
    );

endmodule

//--- include/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Each row holds the kind, ALU op, program bytes, pin_pi, strobe count,
// expected {pin_pa, pin_po} pairs and final PC
// Kind 0 runs the program as listed while kind 1 and 2 build an ALU test
// with register or immediate operands from random values
typedef struct packed {
    logic [1:0]        kind;
    logic [2:0]        op;
    logic [0:15][7:0]  prog;
    logic [7:0]        pi;
    logic [2:0]        n_out;
    logic [0:3][15:0]  outs;
    logic [15:0]       final_pc;
} test_row_t;

localparam int num_rows = 25;

localparam test_row_t test_rows [num_rows] = '{
    // MVI B, then MOV through C, D, E, H, L, A and OUT
    '{2'd0, 3'd0, 128'h065a_4851_5a63_6c7d_d310_7600_0000_0000, 8'h00, 3'd1,
      64'h105a_0000_0000_0000, 16'h000b},
    // LXI B and D with B, C and D shown through A
    '{2'd0, 3'd0, 128'h0134_1211_7856_78d3_2079_d321_7ad3_2276, 8'h00, 3'd3,
      64'h2012_2134_2256_0000, 16'h0010},
    // LXI D with E shown through A
    '{2'd0, 3'd0, 128'h1178_567b_d323_7600_0000_0000_0000_0000, 8'h00, 3'd1,
      64'h2378_0000_0000_0000, 16'h0007},
    // NOP, LXI H and SP
    '{2'd0, 3'd0, 128'h0021_bc9a_31ef_be7c_d330_7dd3_3176_0000, 8'h00, 3'd2,
      64'h309a_31bc_0000_0000, 16'h000e},
    // JMP over a HLT, then IN and OUT
    '{2'd0, 3'd0, 128'hc304_0076_db40_d341_7600_0000_0000_0000, 8'hc3, 3'd1,
      64'h41c3_0000_0000_0000, 16'h0009},
    // SUB to zero, JZ taken, JC not taken
    '{2'd0, 3'd0, 128'h3e05_d605_ca0a_00d3_0176_da10_00d3_0276, 8'h00, 3'd1,
      64'h0200_0000_0000_0000, 16'h0010},
    // Signed overflow, JPE taken, JP not taken
    '{2'd0, 3'd0, 128'h3e70_c620_ea0a_00d3_0176_f210_00d3_0276, 8'h00, 3'd1,
      64'h0290_0000_0000_0000, 16'h0010},
    // AND with even parity, JPO not taken, JNC taken
    '{2'd0, 3'd0, 128'h3e03_e60f_e20f_00d2_0c00_7600_d303_7676, 8'h00, 3'd1,
      64'h0303_0000_0000_0000, 16'h000f},
    // CPI with borrow, JNZ and JM taken, A kept
    '{2'd0, 3'd0, 128'h3e10_fe20_c208_0076_fa0d_0076_76d3_0676, 8'h00, 3'd1,
      64'h0610_0000_0000_0000, 16'h0010},
    // ALU operations on registers
    '{2'd1, 3'd0, '0, 8'h00, 3'd1, '0, 16'h000d},
    '{2'd1, 3'd1, '0, 8'h00, 3'd1, '0, 16'h000d},
    '{2'd1, 3'd2, '0, 8'h00, 3'd1, '0, 16'h000d},
    '{2'd1, 3'd3, '0, 8'h00, 3'd1, '0, 16'h000d},
    '{2'd1, 3'd4, '0, 8'h00, 3'd1, '0, 16'h000d},
    '{2'd1, 3'd5, '0, 8'h00, 3'd1, '0, 16'h000d},
    '{2'd1, 3'd6, '0, 8'h00, 3'd1, '0, 16'h000d},
    '{2'd1, 3'd7, '0, 8'h00, 3'd1, '0, 16'h000d},
    // ALU operations on immediates
    '{2'd2, 3'd0, '0, 8'h00, 3'd1, '0, 16'h000b},
    '{2'd2, 3'd1, '0, 8'h00, 3'd1, '0, 16'h000b},
    '{2'd2, 3'd2, '0, 8'h00, 3'd1, '0, 16'h000b},
    '{2'd2, 3'd3, '0, 8'h00, 3'd1, '0, 16'h000b},
    '{2'd2, 3'd4, '0, 8'h00, 3'd1, '0, 16'h000b},
    '{2'd2, 3'd5, '0, 8'h00, 3'd1, '0, 16'h000b},
    '{2'd2, 3'd6, '0, 8'h00, 3'd1, '0, 16'h000b},
    '{2'd2, 3'd7, '0, 8'h00, 3'd1, '0, 16'h000b}
};

`endif

//--- verification/tb_kr580_core.sv
`timescale 1ns/1ps

module tb_kr580_core;

    localparam int clk_period = 10;

    `include "tb_programs.svh"

    localparam int timeout_ns = num_rows * 200 * clk_period;

    logic        clock;
    logic        arst_n;
    logic [7:0]  mem_data;
    logic [7:0]  pin_pi;
    logic [15:0] address;
    logic [7:0]  pin_pa;
    logic [7:0]  pin_po;
    logic        pin_pw;
    logic        halted;

    logic [7:0]  mem [0:255];
    logic [31:0] rng;
    logic [15:0] seen [0:3];                    // Captured {pin_pa, pin_po}
    int          seen_count;

    assign mem_data = mem[address[7:0]];        // Asynchronous program memory

    kr580_core u_dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .in      (mem_data),
        .pin_pi  (pin_pi),
        .address (address),
        .pin_pa  (pin_pa),
        .pin_po  (pin_po),
        .pin_pw  (pin_pw),
        .halted  (halted)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    // --------------------------------------------------
    // Reference model and helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Returns {F, result}; F bits are S Z - A - P N C
    function automatic logic [15:0] alu_ref(input logic [2:0] op, input logic [7:0] a,
                                            input logic [7:0] b, input logic cin);
        int         ua;
        int         ub;
        int         c;
        int         sum;
        int         low;
        int         ssum;
        logic [7:0] r;
        logic [7:0] f;
        logic       arith;
        logic       sub;
        ua    = int'(a);
        ub    = int'(b);
        c     = (op == 3'd1 || op == 3'd3) ? int'(cin) : 0;   // Carry only for ADC, SBC
        sub   = (op == 3'd2) || (op == 3'd3) || (op == 3'd7);
        arith = (op < 3'd4) || (op == 3'd7);
        if (sub) begin
            sum  = ua - ub - c;
            low  = (ua % 16) - (ub % 16) - c;
            ssum = int'($signed(a)) - int'($signed(b)) - c;
        end else begin
            sum  = ua + ub + c;
            low  = (ua % 16) + (ub % 16) + c;
            ssum = int'($signed(a)) + int'($signed(b)) + c;
        end
        case (op)
            3'd4:    r = a & b;
            3'd5:    r = a ^ b;
            3'd6:    r = a | b;
            default: r = sum[7:0];
        endcase
        f    = 8'h00;
        f[7] = r[7];
        f[6] = (r == 8'h00);
        f[4] = arith && (low < 0 || low > 15);
        f[2] = arith ? (ssum < -128 || ssum > 127) : ~^r;
        f[1] = sub;
        f[0] = arith && (sum < 0 || sum > 255);
        return {f, r};
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fill_memory();
        for (int j = 0; j < 256; j++) begin
            mem[j] = 8'(j) ^ 8'h5c;
        end
    endtask

    // Two ALU ops where the first sets the carry seen by the second
    task automatic build_alu_program(input test_row_t row, input logic [7:0] a0,
                                     input logic [7:0] b0, input logic [7:0] x,
                                     input logic [7:0] y);
        logic [7:0] opc;
        if (row.kind == 2'd1) begin
            opc     = 8'h80 | {2'b00, row.op, 3'b000};
            mem[0]  = 8'h3e;
            mem[1]  = a0;
            mem[2]  = 8'h06;                    // MVI B
            mem[3]  = b0;
            mem[4]  = opc;
            mem[5]  = 8'h3e;
            mem[6]  = x;
            mem[7]  = 8'h0e;                    // MVI C
            mem[8]  = y;
            mem[9]  = opc | 8'h01;
            mem[10] = 8'hd3;
            mem[11] = 8'h01;
            mem[12] = 8'h76;
        end else begin
            opc     = 8'hc6 | {2'b00, row.op, 3'b000};
            mem[0]  = 8'h3e;
            mem[1]  = a0;
            mem[2]  = opc;
            mem[3]  = b0;
            mem[4]  = 8'h3e;
            mem[5]  = x;
            mem[6]  = opc;
            mem[7]  = y;
            mem[8]  = 8'hd3;
            mem[9]  = 8'h01;
            mem[10] = 8'h76;
        end
    endtask

    task automatic collect_strobes();
        seen_count = 0;
        do begin
            @(negedge clock);
            if (pin_pw) begin
                if (seen_count < 4) begin
                    seen[seen_count] = {pin_pa, pin_po};
                end
                seen_count++;
            end
        end while (!halted);
    endtask

    // --------------------------------------------------
    // Test loop
    // --------------------------------------------------
    initial begin
        test_row_t        row;
        logic [0:3][15:0] exp_outs;
        logic [15:0]      first;
        logic [15:0]      second;
        logic [7:0]       a0;
        logic [7:0]       b0;
        logic [7:0]       x;
        logic [7:0]       y;
        arst_n      = 1'b0;
        pin_pi      = 8'h00;
        rng         = 32'h287c_8c98;
        fill_memory();

        for (int i = 0; i < num_rows; i++) begin
            row      = test_rows[i];
            exp_outs = row.outs;
            @(posedge clock);
            #1;
            arst_n = 1'b0;
            pin_pi = row.pi;
            fill_memory();
            if (row.kind == 2'd0) begin
                for (int j = 0; j < 16; j++) begin
                    mem[j] = row.prog[j];
                end
            end else begin
                rng    = xorshift(rng);
                a0     = rng[7:0];
                b0     = rng[15:8];
                x      = rng[23:16];
                y      = rng[31:24];
                build_alu_program(row, a0, b0, x, y);
                first  = alu_ref(row.op, a0, b0, 1'b0);     // F after reset has CF clear
                second = alu_ref(row.op, x, y, first[8]);
                exp_outs[0] = {8'h01, (row.op == 3'd7) ? x : second[7:0]};
            end
            repeat (8) @(posedge clock);
            #1;
            check("pin_pw", 32'(pin_pw), 32'd0);
            check("halted", 32'(halted), 32'd0);
            check("address", 32'(address), 32'd0);
            check("pin_pa", 32'(pin_pa), 32'd0);
            check("pin_po", 32'(pin_po), 32'd0);
            arst_n = 1'b1;

            collect_strobes();
            check("strobe count", 32'(seen_count), 32'(row.n_out));
            for (int k = 0; k < int'(row.n_out); k++) begin
                check("pin_pa", 32'(seen[k][15:8]), 32'(exp_outs[k][15:8]));
                check("pin_po", 32'(seen[k][7:0]), 32'(exp_outs[k][7:0]));
            end

            // PC must stay parked after HLT
            repeat (3) @(negedge clock);
            check("halted", 32'(halted), 32'd1);
            check("address", 32'(address), 32'(row.final_pc));
        end

        $display("Simulation completed successfully");
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        $display("Watchdog expired before all test programs finished");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

//--- sources.f
+incdir+include
src/kr580_pkg.sv
src/alu.sv
src/register_file.sv
src/instr_decoder.sv
src/instr_sequencer.sv
src/kr580_core.sv
verification/tb_kr580_core.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary -j 0 --top-module tb_kr580_core -f sources.f -o tb_sim

run: compile
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
